// ==== hdl/video_timing_pkg.sv ====
package video_timing_pkg;

  // 60 Hz raster, beam clock domain
  localparam int h_total       = 858;  // clocks per line
  localparam int v_total       = 525;  // lines per frame
  localparam int active_width  = 720;
  localparam int active_height = 480;

  typedef logic [9:0] coord_t;

  typedef struct packed {
    coord_t cx;
    coord_t cy;
    logic   line_start;   // cx == 0
    logic   frame_start;  // cx == 0 and cy == 0
  } beam_t;

  // start inclusive, end exclusive
  typedef struct packed {
    coord_t start_x;
    coord_t end_x;
    coord_t start_y;
    coord_t end_y;
  } view_cfg_t;

  typedef enum logic {
    mode_res = 1'b0,  // one pixel per byte
    mode_mid = 1'b1   // pixels doubled both ways
  } disp_mode_t;

  typedef struct packed {
    view_cfg_t   view;
    disp_mode_t  mode;
    logic        disp_on;
    logic [7:0]  frame_col;  // border index
    logic [16:0] page_addr;  // first word of the bitmap
  } frame_cfg_t;

endpackage

// ==== hdl/vram_pkg.sv ====
package vram_pkg;

  // fetch buffer size, also the credits the fetcher starts with
  localparam int fifo_depth = 8;

  typedef logic [17:0] vram_addr_t;

  // four palette indexes, byte 0 is the leftmost pixel
  typedef logic [31:0] vram_word_t;

  typedef struct packed {
    logic       valid;
    vram_addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic       valid;
    vram_word_t data;
  } rd_rsp_t;

  typedef logic [3:0] credit_t;  // 0 .. fifo_depth

  typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;

endpackage

// ==== hdl/raster_timer.sv ====
module raster_timer (
  input  logic                          clk,
  input  logic                          reset,
  input  video_timing_pkg::frame_cfg_t  cfg_in,
  output video_timing_pkg::beam_t       beam,
  output video_timing_pkg::frame_cfg_t  cfg
);

  video_timing_pkg::coord_t cx;
  video_timing_pkg::coord_t cy;
  logic                     line_last;
  logic                     frame_last;
  logic                     cfg_load;

  assign line_last  = cx == video_timing_pkg::coord_t'(video_timing_pkg::h_total - 1);
  assign frame_last = cy == video_timing_pkg::coord_t'(video_timing_pkg::v_total - 1);

  // the last line already runs on the next frame's settings, so the
  // prefetch of viewport row 0 made there sees the right mode and page
  assign cfg_load = line_last &&
                    cy == video_timing_pkg::coord_t'(video_timing_pkg::v_total - 2);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cx <= '0;
      cy <= '0;
    end else if (line_last) begin
      cx <= '0;
      cy <= frame_last ? '0 : cy + 1'b1;
    end else begin
      cx <= cx + 1'b1;
    end
  end

  // shadow of the register file, never changes inside a picture
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cfg <= '0;  // empty viewport until the first load
    end else if (cfg_load) begin
      cfg <= cfg_in;
    end
  end

  assign beam.cx          = cx;
  assign beam.cy          = cy;
  assign beam.line_start  = cx == '0;
  assign beam.frame_start = cx == '0 && cy == '0;

endmodule

// ==== hdl/vram_fetcher.sv ====
module vram_fetcher (
  input  logic                          clk,
  input  logic                          reset,
  input  video_timing_pkg::beam_t       beam,
  input  video_timing_pkg::frame_cfg_t  cfg,
  input  logic                          credit_return,
  output vram_pkg::rd_req_t             rd_req
);

  video_timing_pkg::coord_t next_row;
  video_timing_pkg::coord_t rel_next;
  video_timing_pkg::coord_t view_width;
  video_timing_pkg::coord_t words_per_line;
  video_timing_pkg::coord_t remaining;  // words still to ask for this line
  vram_pkg::vram_addr_t     addr;
  vram_pkg::credit_t        credits;
  logic                     is_mid;
  logic                     line_end;
  logic                     last_row;
  logic                     row_needed;
  logic                     issue;

  assign is_mid   = cfg.mode == video_timing_pkg::mode_mid;
  assign line_end = beam.cx == video_timing_pkg::coord_t'(video_timing_pkg::active_width);
  assign last_row = beam.cy == video_timing_pkg::coord_t'(video_timing_pkg::v_total - 1);

  // row after this one, wrapping into the next frame
  assign next_row = last_row ? '0 : beam.cy + 1'b1;
  assign rel_next = next_row - cfg.view.start_y;

  // odd mid rows come from the line buffer, no fetch
  assign row_needed = next_row >= cfg.view.start_y &&
                      next_row < cfg.view.end_y &&
                      next_row < video_timing_pkg::active_height &&
                      (!is_mid || !rel_next[0]);

  assign view_width     = cfg.view.end_x - cfg.view.start_x;
  assign words_per_line = is_mid ? view_width >> 3 : view_width >> 2;

  assign issue = remaining != '0 && credits != '0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      remaining <= '0;
      addr      <= '0;
      credits   <= vram_pkg::credit_t'(vram_pkg::fifo_depth);
      rd_req    <= '0;
    end else begin
      // one credit out per request, one back per pop
      credits <= credits - vram_pkg::credit_t'(issue) + vram_pkg::credit_t'(credit_return);

      if (line_end) begin
        remaining <= row_needed ? words_per_line : '0;
      end else if (issue) begin
        remaining <= remaining - 1'b1;
      end

      // first fetch of a frame happens on its preceding last line
      if (line_end && last_row) begin
        addr <= vram_pkg::vram_addr_t'(cfg.page_addr);
      end else if (issue) begin
        addr <= addr + 1'b1;
      end

      rd_req.valid <= issue;
      rd_req.addr  <= addr;
    end
  end

endmodule

// ==== hdl/fetch_fifo.sv ====
module fetch_fifo (
  input  logic                 clk,
  input  logic                 reset,
  input  vram_pkg::rd_rsp_t    wr,
  input  logic                 pop,
  output vram_pkg::vram_word_t head,
  output logic                 empty
);

  vram_pkg::vram_word_t mem [vram_pkg::fifo_depth];
  vram_pkg::fifo_ptr_t  wr_ptr;
  vram_pkg::fifo_ptr_t  rd_ptr;
  vram_pkg::credit_t    count;
  logic                 do_pop;

  assign empty  = count == '0;
  assign do_pop = pop && !empty;  // a pop on empty is dropped
  assign head   = mem[rd_ptr];    // first word falls through

  // no full check, the fetcher never has more in flight than free slots
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + vram_pkg::credit_t'(wr.valid) - vram_pkg::credit_t'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr_ptr] <= wr.data;
    end
  end

endmodule

// ==== hdl/pixel_unpacker.sv ====
module pixel_unpacker (
  input  logic                          clk,
  input  logic                          reset,
  input  video_timing_pkg::beam_t       beam,
  input  video_timing_pkg::frame_cfg_t  cfg,
  input  vram_pkg::vram_word_t          head,
  input  logic                          empty,
  output logic                          pop,
  output video_timing_pkg::coord_t      pix_x,
  output video_timing_pkg::coord_t      pix_y,
  output logic [7:0]                    pix_index,
  output logic                          underrun
);

  video_timing_pkg::coord_t rel_x;
  video_timing_pkg::coord_t rel_y;
  vram_pkg::vram_word_t     hold_word;  // word of the current group
  logic [7:0]               src_byte;
  logic [7:0]               live_pix;
  logic [1:0]               byte_sel;
  logic                     is_mid;
  logic                     in_view;
  logic                     replay;
  logic                     group_start;
  logic                     needs_word;
  logic                     starved;

  // one entry per output pixel of an even mid row
  logic [7:0] line_buf [video_timing_pkg::active_width];

  assign rel_x = beam.cx - cfg.view.start_x;
  assign rel_y = beam.cy - cfg.view.start_y;

  assign in_view = beam.cx >= cfg.view.start_x && beam.cx < cfg.view.end_x &&
                   beam.cy >= cfg.view.start_y && beam.cy < cfg.view.end_y;

  assign is_mid = cfg.mode == video_timing_pkg::mode_mid;
  assign replay = is_mid && rel_y[0];  // odd mid row repeats the one above

  // 4 pixels per word in res, 8 in mid with each byte shown twice
  assign group_start = is_mid ? rel_x[2:0] == 3'd0 : rel_x[1:0] == 2'd0;
  assign byte_sel    = is_mid ? rel_x[2:1] : rel_x[1:0];

  assign needs_word = in_view && !replay && group_start;
  assign pop        = needs_word && !empty;
  assign starved    = needs_word && empty;

  always_comb begin
    if (group_start) begin
      src_byte = starved ? 8'd0 : head[7:0];
    end else begin
      src_byte = hold_word[{byte_sel, 3'b000} +: 8];
    end
  end

  // display off blanks the picture but words are still consumed
  assign live_pix = cfg.disp_on ? src_byte : 8'd0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      underrun <= 1'b0;
    end else if (starved) begin
      underrun <= 1'b1;  // sticky
    end
  end

  // output stage, one clock behind the beam
  always_ff @(posedge clk) begin
    pix_x <= beam.cx;
    pix_y <= beam.cy;
    if (!in_view) begin
      pix_index <= cfg.frame_col;
    end else if (replay) begin
      pix_index <= line_buf[rel_x];
    end else begin
      pix_index <= live_pix;
    end
  end

  always_ff @(posedge clk) begin
    if (needs_word) begin
      hold_word <= starved ? '0 : head;
    end
    if (in_view && !replay && is_mid) begin
      line_buf[rel_x] <= live_pix;  // kept for the odd row below
    end
  end

endmodule

// ==== hdl/super_res_top.sv ====
module super_res_top (
  input  logic                          clk,
  input  logic                          reset,
  input  video_timing_pkg::frame_cfg_t  cfg_in,
  output vram_pkg::rd_req_t             rd_req,
  input  vram_pkg::rd_rsp_t             rd_rsp,
  output video_timing_pkg::coord_t      pix_x,
  output video_timing_pkg::coord_t      pix_y,
  output logic [7:0]                    pix_index,
  output logic                          underrun
);

  video_timing_pkg::beam_t      beam;
  video_timing_pkg::frame_cfg_t cfg;
  vram_pkg::vram_word_t         head;
  logic                         empty;
  logic                         pop;  // also the credit back to the fetcher

  raster_timer raster_timer_inst (
    .clk    (clk),
    .reset  (reset),
    .cfg_in (cfg_in),
    .beam   (beam),
    .cfg    (cfg)
  );

  vram_fetcher vram_fetcher_inst (
    .clk           (clk),
    .reset         (reset),
    .beam          (beam),
    .cfg           (cfg),
    .credit_return (pop),
    .rd_req        (rd_req)
  );

  fetch_fifo fetch_fifo_inst (
    .clk   (clk),
    .reset (reset),
    .wr    (rd_rsp),
    .pop   (pop),
    .head  (head),
    .empty (empty)
  );

  pixel_unpacker pixel_unpacker_inst (
    .clk       (clk),
    .reset     (reset),
    .beam      (beam),
    .cfg       (cfg),
    .head      (head),
    .empty     (empty),
    .pop       (pop),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_index (pix_index),
    .underrun  (underrun)
  );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // held over three rising edges, released just after the third
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #0.5 reset = 1'b0;
  end

endmodule

// ==== test/super_res_tb.sv ====
module super_res_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int frame_cycles = video_timing_pkg::h_total * video_timing_pkg::v_total;

  logic                         clk;
  logic                         reset;
  video_timing_pkg::frame_cfg_t cfg_in;
  vram_pkg::rd_req_t            rd_req;
  vram_pkg::rd_rsp_t            rd_rsp;
  video_timing_pkg::coord_t     pix_x;
  video_timing_pkg::coord_t     pix_y;
  logic [7:0]                   pix_index;
  logic                         underrun;

  video_timing_pkg::frame_cfg_t ref_cfg;      // settings of the frame on screen
  video_timing_pkg::frame_cfg_t cfg_in_prev;
  string                        name_in;
  string                        name_prev;
  string                        test_name;
  logic [7:0]                   exp_pix;
  int                           req_count;
  int                           frames_checked;
  logic [31:0]                  lfsr;
  vram_pkg::vram_addr_t         pend_addr [$];
  int                           pend_due [$];
  int                           cycle;
  int                           last_due;
  int                           beam_pos;   // cx + cy * h_total of the DUT counters
  int                           shown_pos;  // position the pixel outputs should carry

  tb_clock clock_gen (.clk(clk), .reset(reset));

  super_res_top super_res_top_inst (
    .clk       (clk),
    .reset     (reset),
    .cfg_in    (cfg_in),
    .rd_req    (rd_req),
    .rd_rsp    (rd_rsp),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_index (pix_index),
    .underrun  (underrun)
  );

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int random_bits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // byte k of word a holds a*4+k
  function automatic vram_pkg::vram_word_t vram_word(input vram_pkg::vram_addr_t a);
    vram_pkg::vram_word_t w;
    int k;
    for (k = 0; k < 4; k++) begin
      w[8*k +: 8] = 8'(int'(a) * 4 + k);
    end
    return w;
  endfunction

  function automatic logic [7:0] expected_index(input video_timing_pkg::coord_t x,
      input video_timing_pkg::coord_t y, input video_timing_pkg::frame_cfg_t c);
    int col;
    int row;
    int words_per_line;
    int word_addr;
    if (!(x >= c.view.start_x && x < c.view.end_x && y >= c.view.start_y &&
          y < c.view.end_y)) begin
      return c.frame_col;  // border
    end
    if (!c.disp_on) begin
      return 8'd0;
    end
    col = int'(x) - int'(c.view.start_x);
    row = int'(y) - int'(c.view.start_y);
    words_per_line = (int'(c.view.end_x) - int'(c.view.start_x)) / 4;
    if (c.mode == video_timing_pkg::mode_mid) begin
      col = col / 2;  // source pixel shown twice
      row = row / 2;
      words_per_line = words_per_line / 2;
    end
    word_addr = int'(c.page_addr) + row * words_per_line + col / 4;
    return 8'(word_addr * 4 + col % 4);
  endfunction

  function automatic int predicted_requests(input video_timing_pkg::frame_cfg_t c);
    int width;
    int height;
    width  = int'(c.view.end_x) - int'(c.view.start_x);
    height = int'(c.view.end_y) - int'(c.view.start_y);
    if (width <= 0 || height <= 0) begin
      return 0;
    end
    if (c.mode == video_timing_pkg::mode_mid) begin
      return ((height + 1) / 2) * (width / 8);  // even rows only
    end
    return height * (width / 4);
  endfunction

  function automatic video_timing_pkg::frame_cfg_t make_cfg(input int sx, input int ex,
      input int sy, input int ey, input video_timing_pkg::disp_mode_t mode,
      input logic disp_on, input logic [7:0] col, input logic [16:0] page);
    video_timing_pkg::frame_cfg_t c;
    c.view.start_x = video_timing_pkg::coord_t'(sx);
    c.view.end_x   = video_timing_pkg::coord_t'(ex);
    c.view.start_y = video_timing_pkg::coord_t'(sy);
    c.view.end_y   = video_timing_pkg::coord_t'(ey);
    c.mode         = mode;
    c.disp_on      = disp_on;
    c.frame_col    = col;
    c.page_addr    = page;
    return c;
  endfunction

  // in order, 1 to 8 cycles, at most one answer per clock
  always @(posedge clk) begin : vram_model
    int                due;
    vram_pkg::rd_rsp_t next_rsp;
    next_rsp = '0;
    if (reset) begin
      pend_addr.delete();
      pend_due.delete();
      cycle    = 0;
      last_due = 0;
    end else begin
      cycle = cycle + 1;
      if (rd_req.valid) begin
        due = cycle + 1 + random_bits(3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(rd_req.addr);
        pend_due.push_back(due);
      end
      if (pend_due.size() > 0 && pend_due[0] == cycle + 1) begin
        next_rsp.valid = 1'b1;
        next_rsp.data  = vram_word(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
    end
    #0.5;
    rd_rsp = next_rsp;
  end

  // beam steps once per clock from reset, pixels trail it by one clock
  always @(posedge clk) begin : raster_model
    shown_pos <= beam_pos;
    if (reset) begin
      beam_pos <= 0;
    end else begin
      beam_pos <= (beam_pos + 1) % frame_cycles;
    end
  end

  // the shadow loads at the end of row v_total-2, so the frame's settings swap there
  always @(posedge clk) begin : frame_monitor
    int expected_reqs;
    if (reset) begin
      ref_cfg        <= '0;
      cfg_in_prev    <= '0;
      test_name      <= "reset_frame";
      req_count      <= 0;
      frames_checked <= 0;
    end else begin
      cfg_in_prev <= cfg_in;
      name_prev   <= name_in;
      if (pix_x == video_timing_pkg::h_total - 1 && pix_y == video_timing_pkg::v_total - 2) begin
        expected_reqs = predicted_requests(ref_cfg);
        assert (req_count == expected_reqs) else begin
          $display("Fail %s request count expected %0d actual %0d",
                   test_name, expected_reqs, req_count);
          $display("TEST FAILED");
          $fatal(1);
        end
        req_count      <= int'(rd_req.valid);
        ref_cfg        <= cfg_in_prev;
        test_name      <= name_prev;
        frames_checked <= frames_checked + 1;
      end else if (rd_req.valid) begin
        req_count <= req_count + 1;
      end
    end
  end

  always_comb exp_pix = expected_index(pix_x, pix_y, ref_cfg);

  pixel_check: assert property (@(negedge clk) disable iff (reset) pix_index == exp_pix)
    else begin
      $display("Fail %s at x=%0d y=%0d expected %0d actual %0d",
               test_name, pix_x, pix_y, exp_pix, pix_index);
      $display("TEST FAILED");
      $fatal(1);
    end

  position_check: assert property (@(negedge clk) disable iff (reset)
      pix_x == shown_pos % video_timing_pkg::h_total &&
      pix_y == shown_pos / video_timing_pkg::h_total)
    else begin
      $display("Fail %s position expected x=%0d y=%0d actual x=%0d y=%0d", test_name,
               shown_pos % video_timing_pkg::h_total, shown_pos / video_timing_pkg::h_total,
               pix_x, pix_y);
      $display("TEST FAILED");
      $fatal(1);
    end

  underrun_check: assert property (@(negedge clk) disable iff (reset) !underrun)
    else begin
      $display("underrun flag went high, the fetch buffer ran dry");
      $display("TEST FAILED");
      $fatal(1);
    end

  task automatic wait_for_row(input int row, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!(pix_y == row && pix_x == 0)) begin
      if (n == 2 * frame_cycles) begin
        $display("timeout waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1);
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (reset) begin
      if (n == 100) begin
        $display("timeout waiting for reset release");
        $display("TEST FAILED");
        $fatal(1);
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic drive_cfg(input video_timing_pkg::frame_cfg_t c, input string name);
    @(posedge clk);
    #0.5;
    cfg_in  = c;
    name_in = name;
  endtask

  // pages with odd low bits, so the page shows up in the pixel values
  initial begin : stimulus
    lfsr    = 32'h7207;
    rd_rsp  = '0;
    cfg_in  = make_cfg(0, 720, 0, 480, video_timing_pkg::mode_res, 1'b1, 8'h21, 17'h01013);
    name_in = "res_full";
    wait_reset_release();
    wait_for_row(240, "mid frame row");
    wait_for_row(0, "frame start");
    // new border colour mid frame, must wait for the next frame
    wait_for_row(240, "mid frame row");
    drive_cfg(make_cfg(40, 680, 48, 432, video_timing_pkg::mode_mid, 1'b1, 8'h5a,
                       17'h0802d), "mid_double");
    wait_for_row(0, "frame start");
    wait_for_row(240, "mid frame row");
    drive_cfg(make_cfg(80, 560, 100, 400, video_timing_pkg::mode_res, 1'b0, 8'hc3,
                       17'h10039), "display_off");
    wait_for_row(0, "frame start");
    wait_for_row(240, "mid frame row");
    drive_cfg(make_cfg(80, 560, 100, 400, video_timing_pkg::mode_res, 1'b1, 8'h3c,
                       17'h12a05), "display_resume");
    wait_for_row(0, "frame start");
    wait_for_row(240, "mid frame row");
    wait_for_row(0, "frame start");
    if (frames_checked == 5) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("only %0d frame boundaries were seen", frames_checked);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== vlog.f ====
hdl/video_timing_pkg.sv
hdl/vram_pkg.sv
hdl/raster_timer.sv
hdl/vram_fetcher.sv
hdl/fetch_fifo.sv
hdl/pixel_unpacker.sv
hdl/super_res_top.sv
test/tb_clock.sv
test/super_res_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module super_res_tb -f vlog.f -o super_res_sim > build.log 2>&1 \
  && ./obj_dir/super_res_sim > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
